// File: hw/aq32_pkg.sv
package aq32_pkg;

    //////////////////////////////
    // CPU bus
    //////////////////////////////
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [31:0] data_t;     // Data word
    typedef logic [3:0]  bytesel_t;  // One enable per byte lane

    //////////////////////////////
    // Peripheral fields
    //////////////////////////////

    // UART character, bit 8 is the flag bit
    typedef logic [8:0]  esp_data_t;

    typedef logic [8:0]  scrx_t;     // Horizontal scroll in pixels
    typedef logic [7:0]  line_t;     // Video line, Y scroll, IRQ line
    typedef logic [1:0]  gfx_mode_t;
    typedef logic [15:0] key_t;      // Keyboard buffer entry

    typedef logic [15:0] tram_word_t;  // Character and attribute

    //////////////////////////////
    // Address map
    //////////////////////////////

    // 4 KB pages, matched against address bits 31:12
    localparam logic [19:0] PAGE_REGS = 20'h00002;
    localparam logic [19:0] PAGE_TRAM = 20'h00006;

    // Register word offsets, address bits 7:2
    localparam logic [5:0] REG_ESPCTRL  = 6'h00;  // 0x2000
    localparam logic [5:0] REG_ESPDATA  = 6'h01;  // 0x2004
    localparam logic [5:0] REG_VCTRL    = 6'h02;  // 0x2008
    localparam logic [5:0] REG_VSCRX    = 6'h03;  // 0x200C
    localparam logic [5:0] REG_VSCRY    = 6'h04;  // 0x2010
    localparam logic [5:0] REG_VLINE    = 6'h05;  // 0x2014
    localparam logic [5:0] REG_VIRQLINE = 6'h06;  // 0x2018
    localparam logic [5:0] REG_KEYBUF   = 6'h07;  // 0x201C

    //////////////////////////////
    // ESP control register
    //////////////////////////////

    // Sticky flag positions, same bit reads status and clears it
    localparam int unsigned ESPCTRL_OVF_BIT  = 4;
    localparam int unsigned ESPCTRL_FERR_BIT = 3;

endpackage

// File: hw/aq32_bus_decode.sv
`timescale 1ns/1ps

module aq32_bus_decode import aq32_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // CPU side
    input  addr_t      cpu_addr,
    input  logic       cpu_strobe,
    input  logic       cpu_wren,
    output logic       cpu_wait,
    output data_t      cpu_rddata,

    // Region selects and their read data
    output logic       regs_sel,
    input  data_t      regs_rddata,
    output logic       tram_sel,
    input  tram_word_t tram_rddata
);

    logic [19:0] page;
    logic [10:0] prev_word;     // Word address seen last cycle
    logic        prev_vld;
    logic        word_changed;

    //////////////////////////////
    // Region decode
    //////////////////////////////
    assign page = cpu_addr[31:12];

    assign regs_sel = cpu_strobe && (page == PAGE_REGS);
    assign tram_sel = cpu_strobe && (page == PAGE_TRAM);

    //////////////////////////////
    // Wait generation
    //////////////////////////////

    // The text RAM registers its read address every cycle, so
    // its output matches whatever address was on the bus last cycle
    always_ff @(posedge clk) begin
        prev_word <= cpu_addr[11:1];
    end

    // Address history is unknown until the first edge after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_vld <= 1'b0;
        end else begin
            prev_vld <= 1'b1;
        end
    end

    assign word_changed = !prev_vld || (prev_word != cpu_addr[11:1]);

    always_comb begin
        cpu_wait = 1'b0;
        if (tram_sel && !cpu_wren) begin
            cpu_wait = word_changed;  // One cycle, then data valid
        end
    end

    //////////////////////////////
    // Read data mux
    //////////////////////////////
    always_comb begin
        cpu_rddata = '0;        // Unmapped pages read zero
        if (regs_sel) begin
            cpu_rddata = regs_rddata;
        end
        if (tram_sel) begin
            cpu_rddata = {tram_rddata, tram_rddata};  // Same word on both halves
        end
    end

endmodule

// File: hw/aq32_regs.sv
`timescale 1ns/1ps

module aq32_regs import aq32_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // From the bus fabric
    input  logic      regs_sel,
    input  logic      cpu_wren,
    input  addr_t     cpu_addr,
    input  data_t     cpu_wrdata,
    output data_t     regs_rddata,

    // ESP UART FIFOs
    output esp_data_t esp_tx_data,
    output logic      esp_tx_wr,
    input  logic      esp_tx_full,
    input  esp_data_t esp_rx_data,
    output logic      esp_rx_rd,
    input  logic      esp_rx_empty,
    input  logic      esp_rx_overflow,
    input  logic      esp_rx_framing_error,

    // Keyboard buffer
    output logic      kbbuf_rd,
    output logic      kbbuf_flush,
    input  key_t      kbbuf_rddata,
    input  logic      kbbuf_empty,

    // Video control
    input  line_t     vline,
    output logic      vctrl_80_columns,
    output logic      vctrl_text_priority,
    output logic      vctrl_sprites_enable,
    output gfx_mode_t vctrl_gfx_mode,
    output logic      vctrl_text_enable,
    output scrx_t     vscrx,
    output line_t     vscry,
    output line_t     virqline
);

    logic [5:0] offset;
    logic       sel_espctrl;
    logic       sel_espdata;
    logic       sel_vctrl;
    logic       sel_vscrx;
    logic       sel_vscry;
    logic       sel_virqline;
    logic       sel_keybuf;
    logic       rx_ovf;         // Sticky RX FIFO overflow
    logic       rx_ferr;        // Sticky framing error

    //////////////////////////////
    // Offset decode
    //////////////////////////////
    assign offset = cpu_addr[7:2];

    assign sel_espctrl  = regs_sel && (offset == REG_ESPCTRL);
    assign sel_espdata  = regs_sel && (offset == REG_ESPDATA);
    assign sel_vctrl    = regs_sel && (offset == REG_VCTRL);
    assign sel_vscrx    = regs_sel && (offset == REG_VSCRX);
    assign sel_vscry    = regs_sel && (offset == REG_VSCRY);
    assign sel_virqline = regs_sel && (offset == REG_VIRQLINE);
    assign sel_keybuf   = regs_sel && (offset == REG_KEYBUF);

    // Peripheral strobes, one per strobe cycle
    assign esp_tx_data = cpu_wrdata[8:0];
    assign esp_tx_wr   = sel_espdata && cpu_wren;
    assign esp_rx_rd   = sel_espdata && !cpu_wren;
    assign kbbuf_rd    = sel_keybuf && !cpu_wren;   // Pop on read
    assign kbbuf_flush = sel_keybuf && cpu_wren;    // Any write empties it

    //////////////////////////////
    // Control registers
    //////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_ovf               <= 1'b0;
            rx_ferr              <= 1'b0;
            vctrl_80_columns     <= 1'b0;
            vctrl_text_priority  <= 1'b0;
            vctrl_sprites_enable <= 1'b0;
            vctrl_gfx_mode       <= '0;
            vctrl_text_enable    <= 1'b0;
            vscrx                <= '0;
            vscry                <= '0;
            virqline             <= '0;
        end else begin
            if (cpu_wren) begin
                if (sel_espctrl) begin
                    // Write 1 to clear
                    rx_ovf  <= rx_ovf && !cpu_wrdata[ESPCTRL_OVF_BIT];
                    rx_ferr <= rx_ferr && !cpu_wrdata[ESPCTRL_FERR_BIT];
                end
                if (sel_vctrl) begin
                    vctrl_80_columns     <= cpu_wrdata[6];
                    vctrl_text_priority  <= cpu_wrdata[4];
                    vctrl_sprites_enable <= cpu_wrdata[3];
                    vctrl_gfx_mode       <= cpu_wrdata[2:1];
                    vctrl_text_enable    <= cpu_wrdata[0];
                end
                if (sel_vscrx)    vscrx    <= cpu_wrdata[8:0];
                if (sel_vscry)    vscry    <= cpu_wrdata[7:0];
                if (sel_virqline) virqline <= cpu_wrdata[7:0];
            end

            // A new event wins over a clear in the same cycle
            if (esp_rx_overflow)      rx_ovf  <= 1'b1;
            if (esp_rx_framing_error) rx_ferr <= 1'b1;
        end
    end

    //////////////////////////////
    // Read words
    //////////////////////////////
    always_comb begin
        regs_rddata = '0;
        case (offset)
            REG_ESPCTRL: begin
                regs_rddata[ESPCTRL_OVF_BIT]  = rx_ovf;
                regs_rddata[ESPCTRL_FERR_BIT] = rx_ferr;
                regs_rddata[1]                = esp_tx_full;
                regs_rddata[0]                = !esp_rx_empty;  // RX data available
            end
            REG_ESPDATA:  regs_rddata = {23'b0, esp_rx_data};
            REG_VCTRL: begin
                regs_rddata = {25'b0, vctrl_80_columns, 1'b0, vctrl_text_priority,
                               vctrl_sprites_enable, vctrl_gfx_mode, vctrl_text_enable};
            end
            REG_VSCRX:    regs_rddata = {23'b0, vscrx};
            REG_VSCRY:    regs_rddata = {24'b0, vscry};
            REG_VLINE:    regs_rddata = {24'b0, vline};
            REG_VIRQLINE: regs_rddata = {24'b0, virqline};
            REG_KEYBUF:   regs_rddata = {kbbuf_empty, 15'b0, kbbuf_rddata};
            default:      regs_rddata = '0;
        endcase
    end

endmodule

// File: hw/aq32_kbbuf.sv
`timescale 1ns/1ps

module aq32_kbbuf import aq32_pkg::*; #(
    parameter int KBBUF_DEPTH = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,

    input  key_t wrdata,
    input  logic wr_en,

    output key_t rddata,    // Head of the queue, valid while not empty
    input  logic rd_en,
    output logic empty
);

    localparam int AW = $clog2(KBBUF_DEPTH);
    localparam int CW = $clog2(KBBUF_DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(KBBUF_DEPTH - 1);

    key_t          mem [KBBUF_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign full  = (count == CW'(KBBUF_DEPTH));

    // Drop keys when full, ignore pops when empty
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign rddata = mem[rd_ptr];  // Show-ahead

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wrdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;

            // Fill level
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/aq32_tram.sv
`timescale 1ns/1ps

module aq32_tram import aq32_pkg::*; #(
    parameter int TRAM_WORDS = 1024
) (
    input  logic       clk,
    input  logic       sel,
    input  logic       wren,
    input  addr_t      addr,
    input  tram_word_t wrdata,
    input  logic [1:0] lanes,   // Bit 1 is the high byte
    output tram_word_t rddata
);

    localparam int AW = $clog2(TRAM_WORDS);

    tram_word_t    mem [TRAM_WORDS];
    logic [AW-1:0] word;
    logic          wr;
    tram_word_t    merged;

    // Text area repeats inside its page above TRAM_WORDS
    assign word = addr[AW:1];
    assign wr   = sel && wren;

    // Stored word with the written lanes replaced
    assign merged = {lanes[1] ? wrdata[15:8] : mem[word][15:8],
                     lanes[0] ? wrdata[7:0]  : mem[word][7:0]};

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[word] <= merged;
        end
    end

    //////////////////////////////
    // Registered read
    //////////////////////////////

    // Write-first, so a read right after a write to the same word sees new data
    always_ff @(posedge clk) begin
        rddata <= wr ? merged : mem[word];
    end

endmodule

// File: hw/aq32_top.sv
`timescale 1ns/1ps

module aq32_top import aq32_pkg::*; #(
    parameter int KBBUF_DEPTH = 16,
    parameter int TRAM_WORDS  = 1024
) (
    input  logic      clk,
    input  logic      reset,

    // CPU bus
    input  addr_t     cpu_addr,
    input  data_t     cpu_wrdata,
    input  bytesel_t  cpu_bytesel,
    input  logic      cpu_wren,
    input  logic      cpu_strobe,
    output logic      cpu_wait,
    output data_t     cpu_rddata,

    // ESP UART FIFOs
    output esp_data_t esp_tx_data,
    output logic      esp_tx_wr,
    input  logic      esp_tx_full,
    input  esp_data_t esp_rx_data,
    output logic      esp_rx_rd,
    input  logic      esp_rx_empty,
    input  logic      esp_rx_overflow,
    input  logic      esp_rx_framing_error,

    // Keyboard data from the SPI side
    input  key_t      kbbuf_wrdata,
    input  logic      kbbuf_wren,

    // Video
    input  line_t     vline,
    output logic      vctrl_80_columns,
    output logic      vctrl_text_priority,
    output logic      vctrl_sprites_enable,
    output gfx_mode_t vctrl_gfx_mode,
    output logic      vctrl_text_enable,
    output scrx_t     vscrx,
    output line_t     vscry,
    output line_t     virqline
);

    logic       regs_sel;
    data_t      regs_rddata;
    logic       tram_sel;
    tram_word_t tram_rddata;
    logic [1:0] tram_lanes;
    logic       kbbuf_rd;
    logic       kbbuf_flush;
    key_t       kbbuf_rddata;
    logic       kbbuf_empty;

    // 16-bit RAM, either byte pair selects the same lane
    assign tram_lanes = cpu_bytesel[3:2] | cpu_bytesel[1:0];

    //////////////////////////////
    // Bus fabric
    //////////////////////////////
    aq32_bus_decode decode0 (
        .clk         (clk),
        .reset       (reset),
        .cpu_addr    (cpu_addr),
        .cpu_strobe  (cpu_strobe),
        .cpu_wren    (cpu_wren),
        .cpu_wait    (cpu_wait),
        .cpu_rddata  (cpu_rddata),
        .regs_sel    (regs_sel),
        .regs_rddata (regs_rddata),
        .tram_sel    (tram_sel),
        .tram_rddata (tram_rddata)
    );

    //////////////////////////////
    // Peripherals
    //////////////////////////////
    aq32_regs regs0 (
        .clk                  (clk),
        .reset                (reset),
        .regs_sel             (regs_sel),
        .cpu_wren             (cpu_wren),
        .cpu_addr             (cpu_addr),
        .cpu_wrdata           (cpu_wrdata),
        .regs_rddata          (regs_rddata),
        .esp_tx_data          (esp_tx_data),
        .esp_tx_wr            (esp_tx_wr),
        .esp_tx_full          (esp_tx_full),
        .esp_rx_data          (esp_rx_data),
        .esp_rx_rd            (esp_rx_rd),
        .esp_rx_empty         (esp_rx_empty),
        .esp_rx_overflow      (esp_rx_overflow),
        .esp_rx_framing_error (esp_rx_framing_error),
        .kbbuf_rd             (kbbuf_rd),
        .kbbuf_flush          (kbbuf_flush),
        .kbbuf_rddata         (kbbuf_rddata),
        .kbbuf_empty          (kbbuf_empty),
        .vline                (vline),
        .vctrl_80_columns     (vctrl_80_columns),
        .vctrl_text_priority  (vctrl_text_priority),
        .vctrl_sprites_enable (vctrl_sprites_enable),
        .vctrl_gfx_mode       (vctrl_gfx_mode),
        .vctrl_text_enable    (vctrl_text_enable),
        .vscrx                (vscrx),
        .vscry                (vscry),
        .virqline             (virqline)
    );

    aq32_kbbuf #(
        .KBBUF_DEPTH (KBBUF_DEPTH)
    ) kbbuf0 (
        .clk    (clk),
        .reset  (reset),
        .flush  (kbbuf_flush),
        .wrdata (kbbuf_wrdata),
        .wr_en  (kbbuf_wren),
        .rddata (kbbuf_rddata),
        .rd_en  (kbbuf_rd),
        .empty  (kbbuf_empty)
    );

    aq32_tram #(
        .TRAM_WORDS (TRAM_WORDS)
    ) tram0 (
        .clk    (clk),
        .sel    (tram_sel),
        .wren   (cpu_wren),
        .addr   (cpu_addr),
        .wrdata (cpu_wrdata[15:0]),
        .lanes  (tram_lanes),
        .rddata (tram_rddata)
    );

endmodule

// File: dv/aq32_sva.sv
`timescale 1ns/1ps

module aq32_sva import aq32_pkg::*; (
    input logic      clk,
    input logic      reset,
    input addr_t     cpu_addr,
    input data_t     cpu_wrdata,
    input logic      cpu_wren,
    input logic      cpu_strobe,
    input logic      cpu_wait,
    input logic      tram_sel,
    input logic      esp_tx_wr,
    input esp_data_t esp_tx_data,
    input logic      vctrl_80_columns,
    input logic      vctrl_text_priority,
    input logic      vctrl_sprites_enable,
    input gfx_mode_t vctrl_gfx_mode,
    input logic      vctrl_text_enable,
    input scrx_t     vscrx,
    input line_t     vscry,
    input line_t     virqline
);

    int errors = 0;     // Read by the testbench

    //////////////////////////////
    // Bus timing
    //////////////////////////////
    a_no_wait_on_write: assert property (@(posedge clk) disable iff (reset)
        (cpu_strobe && cpu_wren) |-> !cpu_wait)
    else begin
        $error("cpu_wait was high during a write");
        errors++;
    end

    // New text RAM word, one wait cycle then data
    a_tram_one_wait: assert property (@(posedge clk) disable iff (reset)
        (tram_sel && !cpu_wren && cpu_addr[11:1] != $past(cpu_addr[11:1]))
        |-> cpu_wait ##1 !cpu_wait)
    else begin
        $error("text RAM read to a new word did not wait exactly one cycle");
        errors++;
    end

    //////////////////////////////
    // Peripheral outputs
    //////////////////////////////
    a_tx_data: assert property (@(posedge clk) disable iff (reset)
        esp_tx_wr |-> (esp_tx_data == cpu_wrdata[8:0]))
    else begin
        $error("esp_tx_data does not match the low bits of the write data");
        errors++;
    end

    a_reset_outputs: assert property (@(posedge clk)
        reset |-> (!vctrl_80_columns && !vctrl_text_priority && !vctrl_sprites_enable
                   && vctrl_gfx_mode == '0 && !vctrl_text_enable
                   && vscrx == '0 && vscry == '0 && virqline == '0))
    else begin
        $error("video control outputs not zero during reset");
        errors++;
    end

endmodule

// File: dv/tb_aq32_top.sv
`timescale 1ns/1ps

module tb_aq32_top import aq32_pkg::*; ();

    localparam int    KBBUF_DEPTH = 16;
    localparam int    TIMEOUT     = 20;     // Wait cycles per access
    localparam addr_t REGS_BASE   = {PAGE_REGS, 12'h000};
    localparam addr_t TRAM_BASE   = {PAGE_TRAM, 12'h000};

    logic      clk;
    logic      reset;
    addr_t     cpu_addr;
    data_t     cpu_wrdata;
    bytesel_t  cpu_bytesel;
    logic      cpu_wren;
    logic      cpu_strobe;
    logic      cpu_wait;
    data_t     cpu_rddata;
    esp_data_t esp_tx_data;
    logic      esp_tx_wr;
    logic      esp_tx_full;
    esp_data_t esp_rx_data;
    logic      esp_rx_rd;
    logic      esp_rx_empty;
    logic      esp_rx_overflow;
    logic      esp_rx_framing_error;
    key_t      kbbuf_wrdata;
    logic      kbbuf_wren;
    line_t     vline;
    logic      vctrl_80_columns;
    logic      vctrl_text_priority;
    logic      vctrl_sprites_enable;
    gfx_mode_t vctrl_gfx_mode;
    logic      vctrl_text_enable;
    scrx_t     vscrx;
    line_t     vscry;
    line_t     virqline;

    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          test_err0 = 0;
    int          tx_count = 0;
    int          rx_count = 0;
    esp_data_t   tx_last;
    logic [31:0] rng = 32'hbc66_3925;

    aq32_top #(.KBBUF_DEPTH(KBBUF_DEPTH), .TRAM_WORDS(1024)) dut0 (.*);

    bind aq32_top aq32_sva sva0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // UART strobe monitor
    always @(posedge clk) begin
        if (esp_tx_wr) begin
            tx_count <= tx_count + 1;
            tx_last  <= esp_tx_data;
        end
        if (esp_rx_rd) rx_count <= rx_count + 1;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic addr_t reg_addr(input logic [5:0] off);
        return REGS_BASE | {off, 2'b00};
    endfunction

    function automatic int total_errors();
        return errors + dut0.sva0.errors;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // One access, returns at the falling edge after it completes
    task automatic bus_access(input addr_t a, input data_t d, input bytesel_t be,
                              input logic wr, output data_t rd, output int waits);
        @(posedge clk);
        cpu_addr    <= a;
        cpu_wrdata  <= d;
        cpu_bytesel <= be;
        cpu_wren    <= wr;
        cpu_strobe  <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (cpu_wait && waits < TIMEOUT) begin
            waits++;
            @(negedge clk);
        end
        if (cpu_wait) begin
            $display("Bus access to %h never completed, wait stuck high", a);
            errors++;
        end
        rd = cpu_rddata;
        @(posedge clk);
        cpu_strobe <= 1'b0;
        cpu_wren   <= 1'b0;
        @(negedge clk);
    endtask

    task automatic cpu_write(input addr_t a, input data_t d, input bytesel_t be);
        data_t rd;
        int    waits;
        bus_access(a, d, be, 1'b1, rd, waits);
    endtask

    task automatic cpu_read(input addr_t a, output data_t d, output int waits);
        bus_access(a, '0, 4'hf, 1'b0, d, waits);
    endtask

    task automatic key_push(input key_t k);
        @(posedge clk);
        kbbuf_wrdata <= k;
        kbbuf_wren   <= 1'b1;
        @(posedge clk);
        kbbuf_wren   <= 1'b0;
    endtask

    task automatic test_done(input string name);
        tests++;
        if (total_errors() == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed", name);
        end
        test_err0 = total_errors();
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    initial begin
        data_t       rd;
        int          waits;
        logic [31:0] r;
        logic [31:0] q;
        int          n0;
        key_t        keys[$];
        addr_t       ta[6];
        tram_word_t  model[6];
        bytesel_t    be_pat[6];

        reset = 1'b1;
        cpu_addr = '0;
        cpu_wrdata = '0;
        cpu_bytesel = '0;
        cpu_wren = 1'b0;
        cpu_strobe = 1'b0;
        esp_tx_full = 1'b0;
        esp_rx_data = '0;
        esp_rx_empty = 1'b1;
        esp_rx_overflow = 1'b0;
        esp_rx_framing_error = 1'b0;
        kbbuf_wrdata = '0;
        kbbuf_wren = 1'b0;
        vline = '0;
        be_pat = '{4'b0001, 4'b1000, 4'b0100, 4'b0010, 4'b1001, 4'b0000};
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int off = 0; off < REG_KEYBUF; off++) begin
            cpu_read(reg_addr(off), rd, waits);
            expect_eq("reset_value", 32'h0, rd);
        end
        cpu_read(reg_addr(REG_KEYBUF), rd, waits);
        expect_eq("reset_keybuf_empty", 1, rd[31]);
        for (int i = 0; i < 4; i++) begin
            r = xorshift();
            q = xorshift();
            cpu_write(reg_addr(REG_VCTRL), r, 4'hf);
            cpu_read(reg_addr(REG_VCTRL), rd, waits);
            expect_eq("vctrl", r & 32'h5f, rd);
            expect_eq("vctrl_out", r[6:0] & 7'h5f, {vctrl_80_columns, 1'b0,
                      vctrl_text_priority, vctrl_sprites_enable, vctrl_gfx_mode,
                      vctrl_text_enable});
            cpu_write(reg_addr(REG_VSCRX), r, 4'hf);
            cpu_read(reg_addr(REG_VSCRX), rd, waits);
            expect_eq("vscrx", r & 32'h1ff, rd);
            expect_eq("vscrx_out", r[8:0], vscrx);
            cpu_write(reg_addr(REG_VIRQLINE), q, 4'hf);
            cpu_write(reg_addr(REG_VSCRY), r, 4'hf);   // Must not touch virqline
            cpu_read(reg_addr(REG_VSCRY), rd, waits);
            expect_eq("vscry", r & 32'hff, rd);
            cpu_read(reg_addr(REG_VIRQLINE), rd, waits);
            expect_eq("virqline", q & 32'hff, rd);
            expect_eq("vscry_out", r[7:0], vscry);
            expect_eq("virqline_out", q[7:0], virqline);
        end
        test_done("reset_and_regs");

        r = xorshift();
        @(posedge clk);
        vline <= r[7:0];
        cpu_read(reg_addr(REG_VLINE), rd, waits);
        expect_eq("vline", r & 32'hff, rd);
        test_done("vline");

        // ESP data in both directions
        r = xorshift();
        n0 = tx_count;
        cpu_write(reg_addr(REG_ESPDATA), r, 4'hf);
        expect_eq("esp_tx_wr_count", n0 + 1, tx_count);
        expect_eq("esp_tx_data", r[8:0], tx_last);
        @(posedge clk);
        esp_rx_data  <= r[24:16];
        esp_rx_empty <= 1'b0;
        n0 = rx_count;
        cpu_read(reg_addr(REG_ESPDATA), rd, waits);
        expect_eq("esp_rx_data", {23'b0, r[24:16]}, rd);
        expect_eq("esp_rx_rd_count", n0 + 1, rx_count);
        @(posedge clk);
        esp_tx_full <= 1'b1;
        cpu_read(reg_addr(REG_ESPCTRL), rd, waits);
        expect_eq("espctrl_levels", 32'h3, rd);
        @(posedge clk);
        esp_tx_full  <= 1'b0;
        esp_rx_empty <= 1'b1;
        cpu_read(reg_addr(REG_ESPCTRL), rd, waits);
        expect_eq("espctrl_idle", 32'h0, rd);

        // Sticky flags, cleared one at a time
        @(posedge clk);
        esp_rx_overflow <= 1'b1;
        @(posedge clk);
        esp_rx_overflow <= 1'b0;
        cpu_read(reg_addr(REG_ESPCTRL), rd, waits);
        expect_eq("espctrl_ovf", 32'h10, rd);
        @(posedge clk);
        esp_rx_framing_error <= 1'b1;
        @(posedge clk);
        esp_rx_framing_error <= 1'b0;
        cpu_read(reg_addr(REG_ESPCTRL), rd, waits);
        expect_eq("espctrl_both", 32'h18, rd);
        cpu_write(reg_addr(REG_ESPCTRL), 32'h10, 4'hf);
        cpu_read(reg_addr(REG_ESPCTRL), rd, waits);
        expect_eq("espctrl_clr_ovf", 32'h08, rd);
        cpu_write(reg_addr(REG_ESPCTRL), 32'h08, 4'hf);
        cpu_read(reg_addr(REG_ESPCTRL), rd, waits);
        expect_eq("espctrl_clr_ferr", 32'h0, rd);
        test_done("esp");

        // Keys come back in order
        for (int i = 0; i < 5; i++) begin
            r = xorshift();
            key_push(r[15:0]);
            keys.push_back(r[15:0]);
        end
        while (keys.size() > 0) begin
            cpu_read(reg_addr(REG_KEYBUF), rd, waits);
            expect_eq("keybuf_order", {16'b0, keys.pop_front()}, rd);
        end
        cpu_read(reg_addr(REG_KEYBUF), rd, waits);
        expect_eq("keybuf_empty", 1, rd[31]);
        for (int i = 0; i < KBBUF_DEPTH + 3; i++) begin
            r = xorshift();
            key_push(r[15:0]);
            if (i < KBBUF_DEPTH) keys.push_back(r[15:0]);  // Rest is dropped
        end
        while (keys.size() > 0) begin
            cpu_read(reg_addr(REG_KEYBUF), rd, waits);
            expect_eq("keybuf_full", {16'b0, keys.pop_front()}, rd);
        end
        cpu_read(reg_addr(REG_KEYBUF), rd, waits);
        expect_eq("keybuf_full_empty", 1, rd[31]);
        for (int i = 0; i < 3; i++) key_push(xorshift());
        cpu_write(reg_addr(REG_KEYBUF), 32'h0, 4'hf);
        cpu_read(reg_addr(REG_KEYBUF), rd, waits);
        expect_eq("keybuf_flush", 1, rd[31]);
        test_done("kbbuf");

        // Distinct words, then byte lane updates
        for (int i = 0; i < 6; i++) begin
            r = xorshift();
            ta[i] = TRAM_BASE + i * 32'h100 + (r[31:24] & 8'hfe);
            model[i] = r[15:0];
            cpu_write(ta[i], {r[15:0], r[15:0]}, 4'hf);
        end
        for (int i = 0; i < 6; i++) begin
            r = xorshift();
            cpu_write(ta[i], {r[15:0], r[15:0]}, be_pat[i]);
            if (be_pat[i][3] || be_pat[i][1]) model[i][15:8] = r[15:8];
            if (be_pat[i][2] || be_pat[i][0]) model[i][7:0] = r[7:0];
        end
        for (int i = 0; i < 6; i++) begin
            cpu_read(ta[i], rd, waits);
            expect_eq("tram_data", {model[i], model[i]}, rd);
            expect_eq("tram_wait", 1, waits);
            cpu_read(ta[i], rd, waits);
            expect_eq("tram_same_data", {model[i], model[i]}, rd);
            expect_eq("tram_same_wait", 0, waits);
        end
        cpu_read(32'h0000_4010, rd, waits);
        expect_eq("unmapped_data", 32'h0, rd);
        expect_eq("unmapped_wait", 0, waits);
        test_done("tram_and_decode");

        $display("%0d tests, %0d failed, %0d errors", tests, failed, total_errors());
        if (total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
hw/aq32_pkg.sv
hw/aq32_bus_decode.sv
hw/aq32_regs.sv
hw/aq32_kbbuf.sv
hw/aq32_tram.sv
hw/aq32_top.sv
dv/aq32_sva.sv
dv/tb_aq32_top.sv
